// ==== bench/irf_slice_assert.sv ====
/*
  Concurrent checks on the slice outputs, bound into the top level by the testbench.
  Expected read values and busy level come from the testbench model.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_slice_assert
  import irf_types_pkg::*, irf_ecc_pkg::*;
(
  input logic  clk,
  input logic  reset_l,
  input logic  switch_req,
  input logic  switch_busy,
  input word_t rd_data,
  input logic  rd_corrected,
  input logic  rd_uncorrectable
);

  // Count of failed checks that the testbench adds to its report
  int   fail_count = 0;
  logic accepted;

  // The controller only takes a request while idle
  assign accepted = switch_req && !switch_busy;

  read_data_a: assert property (@(posedge clk) disable iff (!reset_l)
    rd_data == irf_slice_tb.exp_rd_data)
    else begin
      $error("ERROR rd_data expected %h got %h",
             $sampled(irf_slice_tb.exp_rd_data), $sampled(rd_data));
      fail_count++;
    end

  corrected_a: assert property (@(posedge clk) disable iff (!reset_l)
    rd_corrected == irf_slice_tb.exp_corrected)
    else begin
      $error("ERROR rd_corrected expected %h got %h",
             $sampled(irf_slice_tb.exp_corrected), $sampled(rd_corrected));
      fail_count++;
    end

  uncorrectable_a: assert property (@(posedge clk) disable iff (!reset_l)
    rd_uncorrectable == irf_slice_tb.exp_uncorrectable)
    else begin
      $error("ERROR rd_uncorrectable expected %h got %h",
             $sampled(irf_slice_tb.exp_uncorrectable), $sampled(rd_uncorrectable));
      fail_count++;
    end

  // An entry is never both repaired and flagged bad
  flags_exclusive_a: assert property (@(posedge clk) disable iff (!reset_l)
    !(rd_corrected && rd_uncorrectable))
    else begin
      $error("corrected and uncorrectable flags both high");
      fail_count++;
    end

  busy_model_a: assert property (@(posedge clk) disable iff (!reset_l)
    switch_busy == irf_slice_tb.exp_busy)
    else begin
      $error("ERROR switch_busy expected %h got %h",
             $sampled(irf_slice_tb.exp_busy), $sampled(switch_busy));
      fail_count++;
    end

  // Busy holds for the save and restore cycles, then falls on the third edge
  busy_hold_a: assert property (@(posedge clk) disable iff (!reset_l)
    ($past(accepted, 1) || $past(accepted, 2)) |-> switch_busy)
    else begin
      $error("switch_busy dropped before the restore cycle ended");
      fail_count++;
    end

  busy_fall_a: assert property (@(posedge clk) disable iff (!reset_l)
    $past(accepted, 3) |-> !switch_busy)
    else begin
      $error("switch_busy still high three edges after an accepted request");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== bench/irf_slice_tb.sv ====
/*
  Testbench for the register file slice. Drives writes, reads and window switches,
  keeps a cycle model of the read port and switch_busy, and prints one line per test.
  The bound assertion module compares the DUT with that model on every edge.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_slice_tb
  import irf_types_pkg::*;
();

  localparam int NUM_WINDOWS = 8;
  localparam int WIN_W = $clog2(NUM_WINDOWS);
  localparam int CLK_PERIOD = 40;
  localparam int DRIVE_DELAY = 2;
  localparam int RESET_CYCLES = 4;
  localparam int RANDOM_WRITES = 24;
  localparam int SWITCH_LIMIT = 8;

  // Cycles spent by each test including the two flush cycles
  localparam int RESET_TEST_CYCLES = RESET_CYCLES + 5;
  localparam int RANDOM_TEST_CYCLES = 3 * RANDOM_WRITES + 2;
  localparam int ECC_TEST_CYCLES = 2 * (5 + 2);
  localparam int SWITCH_TEST_CYCLES = 3 * (SWITCH_LIMIT + 6) + 2 * 2;
  localparam int MARGIN_CYCLES = 40;
  localparam int WATCHDOG_NS = CLK_PERIOD * (RESET_TEST_CYCLES + RANDOM_TEST_CYCLES
                             + ECC_TEST_CYCLES + SWITCH_TEST_CYCLES + MARGIN_CYCLES);

  // How a stored entry was corrupted on its way in
  localparam logic [1:0] KIND_CLEAN = 2'd0;
  localparam logic [1:0] KIND_SINGLE = 2'd1;
  localparam logic [1:0] KIND_DOUBLE = 2'd2;

  logic             clk;
  logic             reset_l;
  logic             wr_en;
  thread_t          wr_thread;
  word_t            wr_data;
  logic [1:0]       inject_err;
  logic             switch_req;
  thread_t          switch_thread;
  logic [WIN_W-1:0] switch_old_win;
  logic [WIN_W-1:0] switch_new_win;
  logic             switch_busy;
  thread_t          rd_thread;
  word_t            rd_data;
  logic             rd_corrected;
  logic             rd_uncorrectable;

  // Reference model with the live entry per thread and the saved copy per window
  word_t            live_word [NUM_THREADS];
  logic [1:0]       live_kind [NUM_THREADS];
  word_t            saved_word [NUM_THREADS][NUM_WINDOWS];
  logic [1:0]       saved_kind [NUM_THREADS][NUM_WINDOWS];
  logic             saved_valid [NUM_THREADS][NUM_WINDOWS];
  logic             pend_valid;
  thread_t          pend_thread;
  word_t            pend_word;
  logic [1:0]       pend_kind;
  int               sw_phase;
  thread_t          sw_thread;
  logic [WIN_W-1:0] sw_old;
  logic [WIN_W-1:0] sw_new;

  // Expected DUT outputs after the latest edge for the bound checks to compare
  word_t            exp_rd_data;
  logic             exp_corrected;
  logic             exp_uncorrectable;
  logic             exp_busy;

  int               seed = 32'h6245_6018;
  int               bench_errors;
  int               errs_at_start;
  int               tests_run;
  int               tests_failed;

  irf_slice #(.NUM_WINDOWS(NUM_WINDOWS)) DUT (
    .clk              (clk),
    .reset_l          (reset_l),
    .wr_en            (wr_en),
    .wr_thread        (wr_thread),
    .wr_data          (wr_data),
    .inject_err       (inject_err),
    .switch_req       (switch_req),
    .switch_thread    (switch_thread),
    .switch_old_win   (switch_old_win),
    .switch_new_win   (switch_new_win),
    .switch_busy      (switch_busy),
    .rd_thread        (rd_thread),
    .rd_data          (rd_data),
    .rd_corrected     (rd_corrected),
    .rd_uncorrectable (rd_uncorrectable)
  );

  bind irf_slice irf_slice_assert u_assert (
    .clk              (clk),
    .reset_l          (reset_l),
    .switch_req       (switch_req),
    .switch_busy      (switch_busy),
    .rd_data          (rd_data),
    .rd_corrected     (rd_corrected),
    .rd_uncorrectable (rd_uncorrectable)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic word_t random_word();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = $random(seed);
    lo = $random(seed);
    return {hi, lo};
  endfunction

  function automatic int error_total();
    return bench_errors + DUT.u_assert.fail_count;
  endfunction

  task automatic init_signals();
    reset_l = 1'b0;
    wr_en = 1'b0;
    wr_thread = '0;
    wr_data = '0;
    inject_err = 2'b00;
    switch_req = 1'b0;
    switch_thread = '0;
    switch_old_win = '0;
    switch_new_win = '0;
    rd_thread = '0;
    bench_errors = 0;
    tests_run = 0;
    tests_failed = 0;
    for (int t = 0; t < NUM_THREADS; t++) begin
      for (int w = 0; w < NUM_WINDOWS; w++) begin
        saved_valid[t][w] = 1'b0;
      end
    end
  endtask

  // Advance the model by one edge, using the inputs that were driven before it
  task automatic update_model();
    thread_t rt;
    if (!reset_l) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        live_word[t] = '0;
        live_kind[t] = KIND_CLEAN;
      end
      pend_valid = 1'b0;
      sw_phase = 0;
      exp_rd_data = '0;
      exp_corrected = 1'b0;
      exp_uncorrectable = 1'b0;
      exp_busy = 1'b0;
    end else begin
      // The read stage takes the entry that was selected before this edge
      rt = rd_thread;
      exp_corrected = (live_kind[rt] == KIND_SINGLE);
      exp_uncorrectable = (live_kind[rt] == KIND_DOUBLE);
      // A double error comes out raw, bits 0 and 1 still flipped
      exp_rd_data = exp_uncorrectable ? (live_word[rt] ^ 64'h3) : live_word[rt];
      // Write registered one edge ago reaches its thread now
      if (pend_valid) begin
        live_word[pend_thread] = pend_word;
        live_kind[pend_thread] = pend_kind;
      end
      // Restore lands two edges after the request and overrides that write
      if (sw_phase == 2 && sw_old != sw_new) begin
        if (!saved_valid[sw_thread][sw_new]) begin
          $display("model restored window %0d of thread %0d before any save to it",
                   sw_new, sw_thread);
          bench_errors++;
        end
        live_word[sw_thread] = saved_word[sw_thread][sw_new];
        live_kind[sw_thread] = saved_kind[sw_thread][sw_new];
      end
      // The saved copy is the entry as it stands one edge after the request
      if (sw_phase == 1) begin
        saved_word[sw_thread][sw_old] = live_word[sw_thread];
        saved_kind[sw_thread][sw_old] = live_kind[sw_thread];
        saved_valid[sw_thread][sw_old] = 1'b1;
        sw_phase = 2;
      end else if (sw_phase == 2) begin
        sw_phase = 0;
      end else if (switch_req) begin
        sw_thread = switch_thread;
        sw_old = switch_old_win;
        sw_new = switch_new_win;
        sw_phase = 1;
      end
      exp_busy = (sw_phase != 0);
      pend_valid = wr_en;
      pend_thread = wr_thread;
      pend_word = wr_data;
      if (inject_err == 2'b00) begin
        pend_kind = KIND_CLEAN;
      end else if (inject_err == 2'b01) begin
        pend_kind = KIND_SINGLE;
      end else begin
        pend_kind = KIND_DOUBLE;
      end
    end
  endtask

  // Wait for the edge, then update the model and drop the one-cycle strobes
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
    update_model();
    wr_en = 1'b0;
    inject_err = 2'b00;
    switch_req = 1'b0;
  endtask

  task automatic drive_write(input thread_t t, input word_t data, input logic [1:0] inj);
    wr_en = 1'b1;
    wr_thread = t;
    wr_data = data;
    inject_err = inj;
  endtask

  task automatic start_test();
    errs_at_start = error_total();
  endtask

  // Flush the read pipe so late mismatches count against this test
  task automatic end_test(input string name);
    int errs;
    repeat (2) next_cycle();
    errs = error_total() - errs_at_start;
    tests_run++;
    if (errs != 0) begin
      tests_failed++;
    end
    $display("test %-20s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
  endtask

  // Switch thread 0 while thread 1 keeps taking writes and both get read
  task automatic switch_window(input logic [WIN_W-1:0] old_win,
                               input logic [WIN_W-1:0] new_win, input logic retry);
    int waited;
    switch_req = 1'b1;
    switch_thread = 1'b0;
    switch_old_win = old_win;
    switch_new_win = new_win;
    next_cycle();
    waited = 0;
    while (switch_busy && waited < SWITCH_LIMIT) begin
      // A second request mid switch has to be dropped
      if (retry && waited == 0) begin
        switch_req = 1'b1;
        switch_old_win = new_win;
        switch_new_win = old_win;
      end
      drive_write(1'b1, random_word(), 2'b00);
      rd_thread = thread_t'(waited % 2);
      next_cycle();
      waited++;
    end
    if (switch_busy) begin
      $display("window switch of thread 0 still busy after %0d cycles", SWITCH_LIMIT);
      bench_errors++;
    end
  endtask

  task automatic after_reset();
    start_test();
    rd_thread = 1'b0;
    next_cycle();
    rd_thread = 1'b1;
    next_cycle();
    next_cycle();
    end_test("after_reset");
  endtask

  // Every round reads the other thread twice, then the written one
  task automatic random_traffic();
    thread_t t;
    start_test();
    for (int i = 0; i < RANDOM_WRITES; i++) begin
      t = thread_t'($random(seed));
      drive_write(t, random_word(), 2'b00);
      rd_thread = ~t;
      next_cycle();
      next_cycle();
      rd_thread = t;
      next_cycle();
    end
    end_test("random_traffic");
  endtask

  task automatic inject_error(input thread_t t, input logic [1:0] inj, input string name);
    start_test();
    drive_write(t, random_word(), inj);
    rd_thread = t;
    repeat (4) next_cycle();
    rd_thread = ~t;
    next_cycle();
    end_test(name);
  endtask

  // Old window equal to new window saves the entry but keeps it live
  task automatic same_window_switch();
    start_test();
    drive_write(1'b0, random_word(), 2'b00);
    rd_thread = 1'b0;
    repeat (2) next_cycle();
    switch_window(3'd3, 3'd3, 1'b0);
    rd_thread = 1'b0;
    repeat (2) next_cycle();
    end_test("same_window_switch");
  endtask

  task automatic save_restore_switch();
    start_test();
    drive_write(1'b0, random_word(), 2'b00);
    rd_thread = 1'b0;
    repeat (2) next_cycle();
    switch_window(3'd0, 3'd3, 1'b0);
    rd_thread = 1'b0;
    next_cycle();
    drive_write(1'b0, random_word(), 2'b00);
    repeat (2) next_cycle();
    switch_window(3'd3, 3'd0, 1'b1);
    rd_thread = 1'b0;
    next_cycle();
    // The writes that thread 1 took during the last switch get read back here
    rd_thread = 1'b1;
    next_cycle();
    end_test("save_restore_switch");
  endtask

  initial begin
    init_signals();
    repeat (RESET_CYCLES) next_cycle();
    reset_l = 1'b1;
    after_reset();
    random_traffic();
    inject_error(1'b1, 2'b01, "single_error");
    inject_error(1'b0, 2'b10, "double_error");
    same_window_switch();
    save_restore_switch();
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, error_total());
    if (error_total() == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

  // Watchdog sized from the cycle count of all tests
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile the slice testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 -f tb.f --top-module irf_slice_tb -o irf_slice_sim \
  || { echo "run.sh: build failed"; exit 1; }
out="$(./obj_dir/irf_slice_sim +verilator+error+limit+1000)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***' \
  && echo "run.sh: simulation passed" \
  || { echo "run.sh: simulation failed"; exit 1; }

// ==== source/irf_ecc_check.sv ====
/*
  Read stage of the slice. Checks the selected entry, repairs a single bit error in
  the data and registers the word with its corrected and uncorrectable flags.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_ecc_check
  import irf_types_pkg::*, irf_ecc_pkg::*;
(
  input  logic   clk,
  input  logic   reset_l,
  input  entry_t sel_entry,
  output word_t  rd_data,
  output logic   rd_corrected,
  output logic   rd_uncorrectable
);

  check_t syn;
  logic   single_err;
  logic   double_err;
  word_t  fixed_data;

  assign syn = ecc_syndrome(sel_entry);

  // Odd overall parity points to one flipped bit, even parity with a
  // nonzero syndrome means two
  assign single_err = (syn != '0) && syn[CHECK_W-1];
  assign double_err = (syn != '0) && !syn[CHECK_W-1];

  // Flip the data bit whose Hamming position the syndrome names
  // A hit on a check bit leaves the data alone
  always_comb begin
    fixed_data = sel_entry[WORD_W-1:0];
    for (int i = 0; i < WORD_W; i++) begin
      if (single_err && (syn[ECC_POS_W-1:0] == ECC_COLS[i])) begin
        fixed_data[i] = !fixed_data[i];
      end
    end
  end

  // On a double error the raw data goes out with the flag set
  always_ff @(posedge clk) begin
    if (!reset_l) begin
      rd_data <= '0;
      rd_corrected <= 1'b0;
      rd_uncorrectable <= 1'b0;
    end else begin
      rd_data <= fixed_data;
      rd_corrected <= single_err;
      rd_uncorrectable <= double_err;
    end
  end

endmodule

`default_nettype wire

// ==== source/irf_ecc_encode.sv ====
/*
  Write stage of the slice. Registers one thread write per cycle, appends the SEC-DED
  check byte and optionally corrupts low bits so the read stage can be exercised.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_ecc_encode
  import irf_types_pkg::*, irf_ecc_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset_l,
  input  logic                   wr_en,
  input  thread_t                wr_thread,
  input  word_t                  wr_data,
  input  logic [1:0]             inject_err,
  output logic [NUM_THREADS-1:0] wrens,
  output entry_t                 wr_data0,
  output entry_t                 wr_data1
);

  word_t      data_q;
  logic [1:0] inject_q;
  entry_t     flip_mask;
  entry_t     entry;

  // One enable per thread, decoded from the write thread number
  always_ff @(posedge clk) begin
    if (!reset_l) begin
      wrens <= '0;
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        wrens[t] <= wr_en && (wr_thread == thread_t'(t));
      end
    end
  end

  // Payload only moves when a write is presented
  always_ff @(posedge clk) begin
    if (wr_en) begin
      data_q <= wr_data;
      inject_q <= inject_err;
    end
  end

  // 01 hits stored bit 0 alone and makes a single error
  // 10 also hits bit 1, which makes a double error
  always_comb begin
    flip_mask = '0;
    flip_mask[0] = (inject_q != 2'b00);
    flip_mask[1] = inject_q[1];
  end

  assign entry = {ecc_encode(data_q), data_q} ^ flip_mask;

  // Every thread sees the same entry and the enables pick who takes it
  assign wr_data0 = entry;
  assign wr_data1 = entry;

endmodule

`default_nettype wire

// ==== source/irf_ecc_pkg.sv ====
/*
  The (72,64) SEC-DED code used on every stored register entry.
  Data bits take the non power of two Hamming positions 3 to 71, check bits 0 to 6 the
  power of two positions, and check bit 7 is overall parity of the whole entry.
*/
`default_nettype none

package irf_ecc_pkg;

  import irf_types_pkg::*;

  // Number of Hamming check bits and so the width of an error position
  localparam int ECC_POS_W = CHECK_W - 1;

  typedef logic [WORD_W-1:0][ECC_POS_W-1:0] ecc_cols_t;
  typedef logic [ECC_POS_W-1:0][WORD_W-1:0] ecc_masks_t;

  // Hamming position of each data bit, skipping the powers of two
  function automatic ecc_cols_t ecc_col_table();
    ecc_cols_t cols;
    int bit_idx;
    cols = '0;
    bit_idx = 0;
    for (int pos = 1; pos < ENTRY_W; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cols[bit_idx] = ECC_POS_W'(pos);
        bit_idx++;
      end
    end
    return cols;
  endfunction

  localparam ecc_cols_t ECC_COLS = ecc_col_table();

  // Check bit j covers every data bit whose position has bit j set
  function automatic ecc_masks_t ecc_mask_table();
    ecc_masks_t masks;
    masks = '0;
    for (int j = 0; j < ECC_POS_W; j++) begin
      for (int i = 0; i < WORD_W; i++) begin
        masks[j][i] = ECC_COLS[i][j];
      end
    end
    return masks;
  endfunction

  localparam ecc_masks_t ECC_MASKS = ecc_mask_table();

  // Check byte for a data word, so that the full entry has even parity
  function automatic check_t ecc_encode(input word_t data);
    check_t chk;
    chk = '0;
    for (int j = 0; j < ECC_POS_W; j++) begin
      chk[j] = ^(data & ECC_MASKS[j]);
    end
    chk[CHECK_W-1] = (^data) ^ (^chk[ECC_POS_W-1:0]);
    return chk;
  endfunction

  // Low bits give the failing Hamming position and the top bit is odd overall parity
  function automatic check_t ecc_syndrome(input entry_t entry);
    check_t calc;
    check_t syn;
    calc = ecc_encode(entry[WORD_W-1:0]);
    syn[ECC_POS_W-1:0] = entry[WORD_W +: ECC_POS_W] ^ calc[ECC_POS_W-1:0];
    syn[CHECK_W-1] = ^entry;
    return syn;
  endfunction

endpackage

`default_nettype wire

// ==== source/irf_register.sv ====
/*
  Register cell of the slice. Holds the live entry of each thread plus a window store
  with a saved copy per thread and window. A save strobe copies a thread entry into
  the store one cycle later, a restore strobe reloads the thread from the store.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_register
  import irf_types_pkg::*;
#(
  parameter  int NUM_WINDOWS = 8,
  localparam int WIN_W       = $clog2(NUM_WINDOWS),
  localparam int ADDR_W      = THREAD_W + WIN_W
) (
  input  logic                   clk,
  input  logic                   reset_l,
  input  logic [NUM_THREADS-1:0] wrens,
  input  logic                   save,
  input  logic [ADDR_W-1:0]      save_addr,
  input  logic                   restore,
  input  logic [ADDR_W-1:0]      restore_addr,
  input  entry_t                 wr_data0,
  input  entry_t                 wr_data1,
  input  thread_t                rd_thread,
  output entry_t                 sel_entry
);

  entry_t            win_store [NUM_THREADS*NUM_WINDOWS];
  entry_t            thread_q  [NUM_THREADS];
  entry_t            wr_bus    [NUM_THREADS];
  logic              save_d;
  logic [ADDR_W-1:0] save_addr_q;
  logic [ADDR_W-1:0] save_slot;
  logic [ADDR_W-1:0] restore_slot;
  thread_t           restore_thread;
  entry_t            save_data;
  entry_t            restore_data;
  logic              reload;

  // Flat store index in thread major order so any window count packs tightly
  function automatic logic [ADDR_W-1:0] slot_of(input logic [ADDR_W-1:0] addr);
    return ADDR_W'(addr[ADDR_W-1 -: THREAD_W]) * ADDR_W'(NUM_WINDOWS)
         + ADDR_W'(addr[WIN_W-1:0]);
  endfunction

  assign wr_bus[0] = wr_data0;
  assign wr_bus[1] = wr_data1;

  // The save is carried one cycle so the store captures the settled thread entry
  always_ff @(posedge clk) begin
    if (!reset_l) begin
      save_d <= 1'b0;
    end else begin
      save_d <= save;
    end
  end

  always_ff @(posedge clk) begin
    save_addr_q <= save_addr;
  end

  assign save_slot = slot_of(save_addr_q);
  assign save_data = thread_q[save_addr_q[ADDR_W-1 -: THREAD_W]];

  // Store write lands on the falling edge half a cycle before the restore reads it
  always_ff @(negedge clk) begin
    if (save_d) begin
      win_store[save_slot] <= save_data;
    end
  end

  // The controller holds restore_addr for the whole strobe, so it indexes directly
  assign restore_slot = slot_of(restore_addr);
  assign restore_thread = restore_addr[ADDR_W-1 -: THREAD_W];
  assign restore_data = win_store[restore_slot];

  // Same slot on both sides means the live entry already matches the store
  assign reload = restore && (save_addr_q != restore_addr);

  // Restore wins over a write to the same thread
  always_ff @(posedge clk) begin
    if (!reset_l) begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        thread_q[t] <= '0;
      end
    end else begin
      for (int t = 0; t < NUM_THREADS; t++) begin
        if (reload && (restore_thread == thread_t'(t))) begin
          thread_q[t] <= restore_data;
        end else if (wrens[t]) begin
          thread_q[t] <= wr_bus[t];
        end
      end
    end
  end

  // Single read port steered by the thread number
  assign sel_entry = thread_q[rd_thread];

endmodule

`default_nettype wire

// ==== source/irf_slice.sv ====
/*
  Top of the register file slice. Chains the write stage, the window controller,
  the register cell and the read stage, and sets the window count for all of them.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_slice
  import irf_types_pkg::*;
#(
  parameter  int NUM_WINDOWS = 8,
  localparam int WIN_W       = $clog2(NUM_WINDOWS),
  localparam int ADDR_W      = THREAD_W + WIN_W
) (
  input  logic             clk,
  input  logic             reset_l,
  input  logic             wr_en,
  input  thread_t          wr_thread,
  input  word_t            wr_data,
  input  logic [1:0]       inject_err,
  input  logic             switch_req,
  input  thread_t          switch_thread,
  input  logic [WIN_W-1:0] switch_old_win,
  input  logic [WIN_W-1:0] switch_new_win,
  output logic             switch_busy,
  input  thread_t          rd_thread,
  output word_t            rd_data,
  output logic             rd_corrected,
  output logic             rd_uncorrectable
);

  logic [NUM_THREADS-1:0] wrens;
  entry_t                 wr_data0;
  entry_t                 wr_data1;
  logic                   save;
  logic                   restore;
  logic [ADDR_W-1:0]      save_addr;
  logic [ADDR_W-1:0]      restore_addr;
  entry_t                 sel_entry;

  irf_ecc_encode u_encode (
    .clk        (clk),
    .reset_l    (reset_l),
    .wr_en      (wr_en),
    .wr_thread  (wr_thread),
    .wr_data    (wr_data),
    .inject_err (inject_err),
    .wrens      (wrens),
    .wr_data0   (wr_data0),
    .wr_data1   (wr_data1)
  );

  irf_window_ctl #(.NUM_WINDOWS(NUM_WINDOWS)) u_window_ctl (
    .clk            (clk),
    .reset_l        (reset_l),
    .switch_req     (switch_req),
    .switch_thread  (switch_thread),
    .switch_old_win (switch_old_win),
    .switch_new_win (switch_new_win),
    .switch_busy    (switch_busy),
    .save           (save),
    .restore        (restore),
    .save_addr      (save_addr),
    .restore_addr   (restore_addr)
  );

  irf_register #(.NUM_WINDOWS(NUM_WINDOWS)) u_register (
    .clk          (clk),
    .reset_l      (reset_l),
    .wrens        (wrens),
    .save         (save),
    .save_addr    (save_addr),
    .restore      (restore),
    .restore_addr (restore_addr),
    .wr_data0     (wr_data0),
    .wr_data1     (wr_data1),
    .rd_thread    (rd_thread),
    .sel_entry    (sel_entry)
  );

  irf_ecc_check u_check (
    .clk              (clk),
    .reset_l          (reset_l),
    .sel_entry        (sel_entry),
    .rd_data          (rd_data),
    .rd_corrected     (rd_corrected),
    .rd_uncorrectable (rd_uncorrectable)
  );

endmodule

`default_nettype wire

// ==== source/irf_types_pkg.sv ====
/*
  Widths, typedefs and the window controller state type for the register file slice.
  Imported by every RTL stage and by the testbench.
*/
`default_nettype none

package irf_types_pkg;

  // The core runs two hardware threads, each with one live entry
  localparam int NUM_THREADS = 2;
  localparam int THREAD_W = $clog2(NUM_THREADS);

  // Architectural data word and the SEC-DED check byte that guards it
  localparam int WORD_W = 64;
  localparam int CHECK_W = 8;
  localparam int ENTRY_W = WORD_W + CHECK_W;

  typedef logic [WORD_W-1:0] word_t;
  typedef logic [CHECK_W-1:0] check_t;

  // Stored entry with the check bits in the high byte and data below
  typedef logic [ENTRY_W-1:0] entry_t;

  // The thread number is also the top bit of every window store address
  typedef logic [THREAD_W-1:0] thread_t;

  // A switch walks through save then restore before going idle again
  typedef enum logic [1:0] {
    WIN_IDLE,
    WIN_SAVING,
    WIN_RESTORING
  } win_ctl_state_t;

endpackage

`default_nettype wire

// ==== source/irf_window_ctl.sv ====
/*
  Window switch sequencer. Accepts a switch request while idle and turns it into one
  save strobe followed by one restore strobe, with thread and window addresses.
*/
`default_nettype none
`timescale 1ns/1ps

module irf_window_ctl
  import irf_types_pkg::*;
#(
  parameter  int NUM_WINDOWS = 8,
  localparam int WIN_W       = $clog2(NUM_WINDOWS),
  localparam int ADDR_W      = THREAD_W + WIN_W
) (
  input  logic              clk,
  input  logic              reset_l,
  input  logic              switch_req,
  input  thread_t           switch_thread,
  input  logic [WIN_W-1:0]  switch_old_win,
  input  logic [WIN_W-1:0]  switch_new_win,
  output logic              switch_busy,
  output logic              save,
  output logic              restore,
  output logic [ADDR_W-1:0] save_addr,
  output logic [ADDR_W-1:0] restore_addr
);

  win_ctl_state_t   state;
  win_ctl_state_t   state_next;
  logic             accept;
  thread_t          thread_q;
  logic [WIN_W-1:0] old_win_q;
  logic [WIN_W-1:0] new_win_q;

  // Requests that arrive mid switch are simply dropped
  assign accept = (state == WIN_IDLE) && switch_req;

  always_comb begin
    state_next = state;
    case (state)
      WIN_IDLE: begin
        if (switch_req) begin
          state_next = WIN_SAVING;
        end
      end
      WIN_SAVING:    state_next = WIN_RESTORING;
      WIN_RESTORING: state_next = WIN_IDLE;
      default:       state_next = WIN_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!reset_l) begin
      state <= WIN_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // Request fields stay put until the next accepted switch
  always_ff @(posedge clk) begin
    if (accept) begin
      thread_q <= switch_thread;
      old_win_q <= switch_old_win;
      new_win_q <= switch_new_win;
    end
  end

  assign switch_busy = (state != WIN_IDLE);
  assign save = (state == WIN_SAVING);
  assign restore = (state == WIN_RESTORING);

  // Thread number sits above the window number in both addresses
  assign save_addr = {thread_q, old_win_q};
  assign restore_addr = {thread_q, new_win_q};

endmodule

`default_nettype wire

// ==== tb.f ====
source/irf_types_pkg.sv
source/irf_ecc_pkg.sv
source/irf_ecc_encode.sv
source/irf_window_ctl.sv
source/irf_register.sv
source/irf_ecc_check.sv
source/irf_slice.sv
bench/irf_slice_assert.sv
bench/irf_slice_tb.sv
